// File: Makefile
# Verilator flow for the SRAM sample buffer

VERILATOR ?= verilator
TOP       ?= sram_fifo_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides the result, not the simulator exit code
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
logic/sbuf_pkg.sv
logic/sample_writer.sv
logic/zbt_sram_ctrl.sv
logic/sample_reader.sv
logic/sram_fifo_top.sv
tb/zbt_sram_model.sv
tb/sram_fifo_chk.sv
tb/sram_fifo_tb.sv

// File: logic/sample_reader.sv
`timescale 1ns/10ps

module sample_reader (
    input  logic                clk,
    input  logic                rst_n,
    // ring pointers
    input  sbuf_pkg::ring_ptr_t wr_ptr,
    output sbuf_pkg::ring_ptr_t rd_ptr,
    // wishbone read master
    output logic                rb_cyc,
    output logic                rb_stb,
    output sbuf_pkg::addr_t     rb_adr,
    input  sbuf_pkg::word_t     rb_dat_r,
    input  logic                rb_ack,
    // outgoing sample stream
    output logic                out_valid,
    output sbuf_pkg::word_t     out_data,
    input  logic                out_ready
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_HOLD
    } rd_state_t;

    rd_state_t       state;
    sbuf_pkg::word_t word_q;
    logic            empty;

    // same pointer, same wrap flag
    assign empty = (rd_ptr == wr_ptr);

    // fetch from the oldest slot
    assign rb_cyc = (state == RD_FETCH);
    assign rb_stb = (state == RD_FETCH);
    assign rb_adr = sbuf_pkg::addr_t'(rd_ptr[sbuf_pkg::RING_ADDR_W-1:0]);

    // word is shown until taken
    assign out_valid = (state == RD_HOLD);
    assign out_data  = word_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= RD_IDLE;
            rd_ptr <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (!empty) begin
                        state <= RD_FETCH;
                    end
                end
                RD_FETCH: begin
                    if (rb_ack) begin
                        state <= RD_HOLD;
                    end
                end
                RD_HOLD: begin
                    // slot is freed only when the sample leaves
                    if (out_ready) begin
                        rd_ptr <= rd_ptr + sbuf_pkg::ring_ptr_t'(1);
                        state  <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RD_FETCH) && rb_ack) begin
            word_q <= rb_dat_r;
        end
    end

endmodule

// File: logic/sample_writer.sv
`timescale 1ns/10ps

module sample_writer (
    input  logic                clk,
    input  logic                rst_n,
    // incoming sample stream
    input  logic                in_valid,
    input  sbuf_pkg::word_t     in_data,
    output logic                in_ready,
    // ring pointers
    input  sbuf_pkg::ring_ptr_t rd_ptr,
    output sbuf_pkg::ring_ptr_t wr_ptr,
    // wishbone write master
    output logic                wa_cyc,
    output logic                wa_stb,
    output sbuf_pkg::addr_t     wa_adr,
    output sbuf_pkg::word_t     wa_dat_w,
    input  logic                wa_ack
);

    typedef enum logic {
        WR_IDLE,
        WR_WRITE
    } wr_state_t;

    wr_state_t           state;
    sbuf_pkg::ring_ptr_t fill;
    sbuf_pkg::word_t     sample_q;
    logic                full;
    logic                run;
    logic                accept;

    // words held in the ring, wrap flag makes this exact
    assign fill = wr_ptr - rd_ptr;
    assign full = (fill == sbuf_pkg::ring_ptr_t'(sbuf_pkg::RING_DEPTH));

    // run stays low through reset and drops in_ready with it
    assign in_ready = run && (state == WR_IDLE) && !full;
    assign accept   = in_valid && in_ready;

    // one open cycle per accepted sample
    assign wa_cyc   = (state == WR_WRITE);
    assign wa_stb   = (state == WR_WRITE);
    assign wa_adr   = sbuf_pkg::addr_t'(wr_ptr[sbuf_pkg::RING_ADDR_W-1:0]);
    assign wa_dat_w = sample_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= WR_IDLE;
            wr_ptr <= '0;
            run    <= 1'b0;
        end else begin
            run <= 1'b1;
            case (state)
                WR_IDLE: begin
                    if (accept) begin
                        state <= WR_WRITE;
                    end
                end
                WR_WRITE: begin
                    // word is committed once the controller acks
                    if (wa_ack) begin
                        wr_ptr <= wr_ptr + sbuf_pkg::ring_ptr_t'(1);
                        state  <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // sample held until its write is acked
    always_ff @(posedge clk) begin
        if (accept) begin
            sample_q <= in_data;
        end
    end

endmodule

// File: logic/sbuf_pkg.sv
package sbuf_pkg;

    // sram word and address widths
    localparam int WORD_W = 18;
    localparam int ADDR_W = 20;

    // byte write lanes on the zbt part
    localparam int BW_W = 2;

    // ring lives in the low address bits only
    localparam int RING_ADDR_W = 6;
    localparam int RING_DEPTH  = 1 << RING_ADDR_W;

    // edges from the address on the pins to its data phase
    localparam int SRAM_LAT = 2;

    // one sram word or stream sample
    typedef logic [WORD_W-1:0] word_t;

    // sram word address
    typedef logic [ADDR_W-1:0] addr_t;

    // ring pointer; msb is the wrap flag
    typedef logic [RING_ADDR_W:0] ring_ptr_t;

endpackage

// File: logic/sram_fifo_top.sv
`timescale 1ns/10ps

module sram_fifo_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // input stream
    input  logic                      in_valid,
    input  sbuf_pkg::word_t           in_data,
    output logic                      in_ready,
    // output stream
    output logic                      out_valid,
    output sbuf_pkg::word_t           out_data,
    input  logic                      out_ready,
    // zbt sram pins
    output sbuf_pkg::addr_t           sram_addr,
    output logic                      sram_we_n,
    output logic                      sram_ce_n,
    output logic                      sram_oe_n,
    output logic                      sram_adv_ld,
    output logic [sbuf_pkg::BW_W-1:0] sram_bw_n,
    output sbuf_pkg::word_t           sram_dq_out,
    output logic                      sram_dq_oe,
    input  sbuf_pkg::word_t           sram_dq_in
);

    sbuf_pkg::ring_ptr_t wr_ptr;
    sbuf_pkg::ring_ptr_t rd_ptr;

    // writer side bus
    logic                wa_cyc;
    logic                wa_stb;
    sbuf_pkg::addr_t     wa_adr;
    sbuf_pkg::word_t     wa_dat_w;
    logic                wa_ack;

    // reader side bus
    logic                rb_cyc;
    logic                rb_stb;
    sbuf_pkg::addr_t     rb_adr;
    sbuf_pkg::word_t     rb_dat_r;
    logic                rb_ack;

    sample_writer u_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .rd_ptr   (rd_ptr),
        .wr_ptr   (wr_ptr),
        .wa_cyc   (wa_cyc),
        .wa_stb   (wa_stb),
        .wa_adr   (wa_adr),
        .wa_dat_w (wa_dat_w),
        .wa_ack   (wa_ack)
    );

    zbt_sram_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wa_cyc      (wa_cyc),
        .wa_stb      (wa_stb),
        .wa_adr      (wa_adr),
        .wa_dat_w    (wa_dat_w),
        .wa_ack      (wa_ack),
        .rb_cyc      (rb_cyc),
        .rb_stb      (rb_stb),
        .rb_adr      (rb_adr),
        .rb_dat_r    (rb_dat_r),
        .rb_ack      (rb_ack),
        .sram_addr   (sram_addr),
        .sram_we_n   (sram_we_n),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_adv_ld (sram_adv_ld),
        .sram_bw_n   (sram_bw_n),
        .sram_dq_out (sram_dq_out),
        .sram_dq_oe  (sram_dq_oe),
        .sram_dq_in  (sram_dq_in)
    );

    sample_reader u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_ptr    (wr_ptr),
        .rd_ptr    (rd_ptr),
        .rb_cyc    (rb_cyc),
        .rb_stb    (rb_stb),
        .rb_adr    (rb_adr),
        .rb_dat_r  (rb_dat_r),
        .rb_ack    (rb_ack),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

// File: logic/zbt_sram_ctrl.sv
`timescale 1ns/10ps

module zbt_sram_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    // write port from the sample writer
    input  logic                          wa_cyc,
    input  logic                          wa_stb,
    input  sbuf_pkg::addr_t               wa_adr,
    input  sbuf_pkg::word_t               wa_dat_w,
    output logic                          wa_ack,
    // read port from the sample reader
    input  logic                          rb_cyc,
    input  logic                          rb_stb,
    input  sbuf_pkg::addr_t               rb_adr,
    output sbuf_pkg::word_t               rb_dat_r,
    output logic                          rb_ack,
    // zbt sram pins
    output sbuf_pkg::addr_t               sram_addr,
    output logic                          sram_we_n,
    output logic                          sram_ce_n,
    output logic                          sram_oe_n,
    output logic                          sram_adv_ld,
    output logic [sbuf_pkg::BW_W-1:0]     sram_bw_n,
    output sbuf_pkg::word_t               sram_dq_out,
    output logic                          sram_dq_oe,
    input  sbuf_pkg::word_t               sram_dq_in
);

    localparam int LAT = sbuf_pkg::SRAM_LAT;

    logic            pend_a;
    logic            pend_b;
    logic            last_a;
    logic            req_a;
    logic            req_b;
    logic            grant_a;
    logic            grant_b;

    // late-write data and read tag pipelines
    logic [LAT:0]    wr_v;
    logic [LAT:0]    rd_v;
    sbuf_pkg::word_t wr_d [LAT+1];

    // single-word cycles, all lanes, always load
    assign sram_adv_ld = 1'b0;
    assign sram_bw_n   = '0;

    // a port with a cycle in flight is not asked again
    assign req_a = wa_cyc && wa_stb && !pend_a;
    assign req_b = rb_cyc && rb_stb && !pend_b;

    // alternating priority when both ask
    assign grant_a = req_a && (!req_b || !last_a);
    assign grant_b = req_b && !grant_a;

    // write ack falls in the cycle after the command edge
    assign wa_ack = pend_a;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_a <= 1'b0;
            pend_b <= 1'b0;
            last_a <= 1'b0;
        end else begin
            if (grant_a) begin
                pend_a <= 1'b1;
            end else if (wa_ack) begin
                pend_a <= 1'b0;
            end
            if (grant_b) begin
                pend_b <= 1'b1;
            end else if (rb_ack) begin
                pend_b <= 1'b0;
            end
            if (grant_a) begin
                last_a <= 1'b1;
            end else if (grant_b) begin
                last_a <= 1'b0;
            end
        end
    end

    // command onto the pins for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_ce_n <= 1'b1;
            sram_we_n <= 1'b1;
        end else begin
            sram_ce_n <= !(grant_a || grant_b);
            sram_we_n <= !grant_a;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_a || grant_b) begin
            sram_addr <= grant_a ? wa_adr : rb_adr;
        end
    end

    // stage k is valid in the cycle starting k edges after the command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_v <= '0;
            rd_v <= '0;
        end else begin
            wr_v <= {wr_v[LAT-1:0], grant_a};
            rd_v <= {rd_v[LAT-1:0], grant_b};
        end
    end

    always_ff @(posedge clk) begin
        if (grant_a) begin
            wr_d[0] <= wa_dat_w;
        end
        for (int i = 1; i <= LAT; i++) begin
            wr_d[i] <= wr_d[i-1];
        end
    end

    // data phase slot
    assign sram_dq_oe  = wr_v[LAT];
    assign sram_dq_out = wr_d[LAT];
    assign sram_oe_n   = !rd_v[LAT];

    // read word sampled at the end of its data phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rb_ack <= 1'b0;
        end else begin
            rb_ack <= rd_v[LAT];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_v[LAT]) begin
            rb_dat_r <= sram_dq_in;
        end
    end

endmodule

// File: tb/sram_fifo_chk.sv
`timescale 1ns/10ps

module sram_fifo_chk (
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input sbuf_pkg::word_t in_data,
    input logic            in_ready,
    input logic            out_valid,
    input sbuf_pkg::word_t out_data,
    input logic            out_ready,
    input logic            wa_cyc,
    input sbuf_pkg::addr_t sram_addr,
    input logic            sram_ce_n,
    input logic            sram_we_n,
    input logic            sram_oe_n,
    input logic            sram_dq_oe,
    input sbuf_pkg::word_t sram_dq_out
);

    localparam int HIST = 1024;

    sbuf_pkg::word_t hist [HIST];
    sbuf_pkg::word_t exp_out;
    sbuf_pkg::word_t exp_wr;
    int              in_n;
    int              out_n;
    int              wp_n;
    int              level;
    int              err_count = 0;
    logic            live;
    logic            in_hs;
    logic            out_hs;
    logic            wr_cmd;
    logic            rd_cmd;

    assign in_hs   = in_valid && in_ready;
    assign out_hs  = out_valid && out_ready;
    assign wr_cmd  = !sram_ce_n && !sram_we_n;
    assign rd_cmd  = !sram_ce_n && sram_we_n;
    assign level   = in_n - out_n;
    assign exp_out = hist[out_n[9:0]];

    // reference queue as a ring of accepted samples
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_n  <= 0;
            out_n <= 0;
            wp_n  <= 0;
            live  <= 1'b0;
        end else begin
            live <= 1'b1;
            if (in_hs) begin
                in_n <= in_n + 1;
            end
            if (out_hs) begin
                out_n <= out_n + 1;
            end
            if (wr_cmd) begin
                wp_n <= wp_n + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && in_hs) begin
            hist[in_n[9:0]] <= in_data;
        end
        // writes reach the pins in input order
        if (rst_n && wr_cmd) begin
            exp_wr <= hist[wp_n[9:0]];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) out_hs |-> out_data == exp_out)
    else begin
        $error("** Error %0t: output sample %h, expected %h", $time, out_data, exp_out);
        err_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) level <= sbuf_pkg::RING_DEPTH)
    else begin
        $error("** Error %0t: %0d samples held, above ring depth", $time, level);
        err_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        level == sbuf_pkg::RING_DEPTH |-> !in_ready)
    else begin
        $error("** Error %0t: in_ready high with the ring full", $time);
        err_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        live && level < sbuf_pkg::RING_DEPTH && !wa_cyc |-> in_ready)
    else begin
        $error("** Error %0t: in_ready low with room and writer idle", $time);
        err_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) level == 0 |-> !out_valid)
    else begin
        $error("** Error %0t: out_valid high with the ring empty", $time);
        err_count++;
    end

    // held word must not move under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        $error("** Error %0t: output changed while stalled", $time);
        err_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        sram_dq_oe == $past(wr_cmd, sbuf_pkg::SRAM_LAT))
    else begin
        $error("** Error %0t: dq_oe %b outside the late-write slot", $time, sram_dq_oe);
        err_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) sram_dq_oe |-> sram_dq_out == exp_wr)
    else begin
        $error("** Error %0t: write data %h, expected %h", $time, sram_dq_out, exp_wr);
        err_count++;
    end

    // output enable only in the read data phase
    assert property (@(posedge clk) disable iff (!rst_n)
        sram_oe_n == !$past(rd_cmd, sbuf_pkg::SRAM_LAT))
    else begin
        $error("** Error %0t: oe_n %b outside the read slot", $time, sram_oe_n);
        err_count++;
    end

    // ring sits in the low address bits
    assert property (@(posedge clk) disable iff (!rst_n)
        !sram_ce_n |-> sram_addr[sbuf_pkg::ADDR_W-1:sbuf_pkg::RING_ADDR_W] == '0)
    else begin
        $error("** Error %0t: sram address %h outside the ring", $time, sram_addr);
        err_count++;
    end

    assert property (@(posedge clk)
        !rst_n |=> !in_ready && !out_valid && !sram_dq_oe && sram_ce_n && sram_we_n)
    else begin
        $error("** Error %0t: outputs not idle around reset", $time);
        err_count++;
    end

endmodule

bind sram_fifo_top sram_fifo_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_ready   (out_ready),
    .wa_cyc      (wa_cyc),
    .sram_addr   (sram_addr),
    .sram_ce_n   (sram_ce_n),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_dq_oe  (sram_dq_oe),
    .sram_dq_out (sram_dq_out)
);

// File: tb/sram_fifo_tb.sv
`timescale 1ns/10ps

module sram_fifo_tb;

    // cycles from command edge to read ack
    localparam int READ_LAT = 3;
    localparam int N_RANDOM = 200;
    localparam int N_FILL   = sbuf_pkg::RING_DEPTH + 8;
    localparam int N_STREAM = 100;
    localparam int TIMEOUT_CYCLES = 4 * (N_RANDOM + N_FILL + N_STREAM) * READ_LAT;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    sbuf_pkg::word_t           in_data;
    logic                      in_ready;
    logic                      out_valid;
    sbuf_pkg::word_t           out_data;
    logic                      out_ready;
    sbuf_pkg::addr_t           sram_addr;
    logic                      sram_we_n;
    logic                      sram_ce_n;
    logic                      sram_oe_n;
    logic                      sram_adv_ld;
    logic [sbuf_pkg::BW_W-1:0] sram_bw_n;
    sbuf_pkg::word_t           sram_dq_out;
    logic                      sram_dq_oe;
    sbuf_pkg::word_t           sram_dq_in;

    logic [15:0] lfsr_state;
    int          phase_mode;
    int          send_target;
    int          sent;
    int          recv;
    int          hold_cycles;
    logic        full_seen;
    int          errors;
    int          cycle_count = 0;

    sram_fifo_top dut (.*);

    zbt_sram_model u_sram (
        .clk         (clk),
        .sram_addr   (sram_addr),
        .sram_we_n   (sram_we_n),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_adv_ld (sram_adv_ld),
        .sram_bw_n   (sram_bw_n),
        .sram_dq_out (sram_dq_out),
        .sram_dq_oe  (sram_dq_oe),
        .sram_dq_in  (sram_dq_in)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic source_go();
        if (phase_mode == 0) begin
            return rand_bits(1) != 32'd0;
        end
        return 1'b1;
    endfunction

    // mode 1 stalls until full, waits a little, then drains
    function automatic logic sink_go();
        case (phase_mode)
            0: return rand_bits(1) != 32'd0;
            1: begin
                if (sent - recv >= sbuf_pkg::RING_DEPTH) begin
                    full_seen = 1'b1;
                end
                if (full_seen) begin
                    hold_cycles++;
                end
                return full_seen && (hold_cycles > 16);
            end
            default: return 1'b1;
        endcase
    endfunction

    // sample handshakes mid-cycle, drive on the rising edge
    task automatic step();
        logic take_in;
        logic take_out;
        @(negedge clk);
        take_in  = in_valid && in_ready;
        take_out = out_valid && out_ready;
        @(posedge clk);
        if (take_in) begin
            sent++;
        end
        if (take_out) begin
            recv++;
        end
        if (take_in || !in_valid) begin
            if (sent < send_target && source_go()) begin
                in_valid <= 1'b1;
                in_data  <= sbuf_pkg::word_t'(rand_bits(sbuf_pkg::WORD_W));
            end else begin
                in_valid <= 1'b0;
            end
        end
        out_ready <= sink_go();
    endtask

    task automatic run_phase(input int mode, input int count);
        phase_mode  = mode;
        send_target = sent + count;
        full_seen   = 1'b0;
        hold_cycles = 0;
        while (sent < send_target || recv < send_target) begin
            step();
        end
    endtask

    initial begin
        lfsr_state = 16'd7485;
        sent       = 0;
        recv       = 0;
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        in_data   <= '0;
        out_ready <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        run_phase(0, N_RANDOM);
        run_phase(1, N_FILL);
        run_phase(2, N_STREAM);
        repeat (4) @(posedge clk);
        errors = dut.u_chk.err_count;
        $display("closing: %0d assertion errors, %0d samples in, %0d samples out",
                 errors, sent, recv);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles with %0d of %0d samples out",
                     cycle_count, recv, sent);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

// File: tb/zbt_sram_model.sv
`timescale 1ns/10ps

module zbt_sram_model (
    input  logic                      clk,
    input  sbuf_pkg::addr_t           sram_addr,
    input  logic                      sram_we_n,
    input  logic                      sram_ce_n,
    input  logic                      sram_oe_n,
    input  logic                      sram_adv_ld,
    input  logic [sbuf_pkg::BW_W-1:0] sram_bw_n,
    input  sbuf_pkg::word_t           sram_dq_out,
    input  logic                      sram_dq_oe,
    output sbuf_pkg::word_t           sram_dq_in
);

    localparam int DEPTH  = sbuf_pkg::RING_DEPTH;
    localparam int STAGES = sbuf_pkg::SRAM_LAT;
    localparam int LANE_W = sbuf_pkg::WORD_W / sbuf_pkg::BW_W;

    sbuf_pkg::word_t                  mem [DEPTH];
    logic [sbuf_pkg::RING_ADDR_W-1:0] a_pipe [STAGES];
    logic [sbuf_pkg::BW_W-1:0]        bw_pipe [STAGES];
    logic [STAGES-1:0]                w_pipe = '0;
    logic [STAGES-1:0]                r_pipe = '0;
    logic                             rd_drive;

    // stale words differ in every address bit
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = sbuf_pkg::word_t'((i * 40503) ^ 'h2A5A5);
        end
    end

    // command taken only in load mode
    always @(posedge clk) begin
        a_pipe[0]  <= sram_addr[sbuf_pkg::RING_ADDR_W-1:0];
        bw_pipe[0] <= sram_bw_n;
        w_pipe[0]  <= !sram_ce_n && !sram_adv_ld && !sram_we_n;
        r_pipe[0]  <= !sram_ce_n && !sram_adv_ld && sram_we_n;
        for (int i = 1; i < STAGES; i++) begin
            a_pipe[i]  <= a_pipe[i-1];
            bw_pipe[i] <= bw_pipe[i-1];
            w_pipe[i]  <= w_pipe[i-1];
            r_pipe[i]  <= r_pipe[i-1];
        end
        // late write, data taken at the end of its phase
        if (w_pipe[STAGES-1] && sram_dq_oe) begin
            for (int l = 0; l < sbuf_pkg::BW_W; l++) begin
                if (!bw_pipe[STAGES-1][l]) begin
                    mem[a_pipe[STAGES-1]][l*LANE_W +: LANE_W] <= sram_dq_out[l*LANE_W +: LANE_W];
                end
            end
        end
    end

    assign rd_drive = r_pipe[STAGES-1] && !sram_oe_n;

    // shared dq bus, x when driven from both sides or floating
    always_comb begin
        if (rd_drive && sram_dq_oe) begin
            sram_dq_in = 'x;
        end else if (rd_drive) begin
            sram_dq_in = mem[a_pipe[STAGES-1]];
        end else if (sram_dq_oe) begin
            sram_dq_in = sram_dq_out;
        end else begin
            sram_dq_in = 'x;
        end
    end

endmodule
